//--- Makefile
# Verilator flow for the RV32I ALU pipeline testbench
TOP := tb_rv_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   lint, build and run $(TOP)"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- build.f
+incdir+src
src/rv_pkg.sv
src/rv_stage_if.sv
src/rv_fetch.sv
src/rv_regs.sv
src/rv_hazard_ctrl.sv
src/rv_id.sv
src/rv_ex.sv
src/rv_core.sv
tests/rv_core_assertions.sv
tests/tb_rv_core.sv

//--- src/rv_core.sv
/*
 * Four-stage RV32I ALU-only core: fetch, decode, execute, writeback.
 * Instruction memory is external and combinational.
 * Fixed latency of three edges from capture to wb_valid_o, in order.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_core (
    input  logic                    clk,
    input  logic                    reset_i,
    // Instruction memory
    input  logic [`XLEN-1:0]        inst_i,
    input  logic                    inst_valid_i,
    output logic [`XLEN-1:0]        inst_addr_o,
    // Register writes, one per cycle
    output logic                    wb_valid_o,
    output logic [`REG_ADDR_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o
);
    import rv_pkg::*;

    // Fetch to decode
    logic [`XLEN-1:0]        fd_inst;
    logic                    fd_valid;
    // Register reads
    logic [`REG_ADDR_W-1:0]  rs1_addr;
    logic [`REG_ADDR_W-1:0]  rs2_addr;
    logic                    rs1_used;
    logic                    rs2_used;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    // Forwarding
    fwd_sel_e                fwd1;
    fwd_sel_e                fwd2;
    logic [`XLEN-1:0]        ex_result;

    // Decode/execute bundle
    rv_stage_if de_if ();

    rv_fetch u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_addr_o  (inst_addr_o),
        .fd_inst_o    (fd_inst),
        .fd_valid_o   (fd_valid)
    );

    // Write port fed straight from the writeback outputs
    rv_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o)
    );

    rv_hazard_ctrl u_hazard (
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_used_i (rs1_used),
        .rs2_used_i (rs2_used),
        .ex         (de_if.mon),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .fwd1_o     (fwd1),
        .fwd2_o     (fwd2)
    );

    rv_id u_id (
        .clk         (clk),
        .reset_i     (reset_i),
        .fd_inst_i   (fd_inst),
        .fd_valid_i  (fd_valid),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_used_o  (rs1_used),
        .rs2_used_o  (rs2_used),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .fwd1_i      (fwd1),
        .fwd2_i      (fwd2),
        .ex_result_i (ex_result),
        .wb_data_i   (wb_data_o),
        .de          (de_if.src)
    );

    rv_ex u_ex (
        .clk         (clk),
        .reset_i     (reset_i),
        .de          (de_if.sink),
        .ex_result_o (ex_result),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

//--- src/rv_defines.svh
/*
 * Shared sizing macros for the RV32I ALU pipeline.
 * XLEN sets both the data path and the instruction word, so it stays 32.
 * REG_ADDR_W of 5 gives the full 32-entry register file.
 * RESET_PC is the first fetch address; the instruction ROM must map it.
 */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ************************************************************************
// Widths
// ************************************************************************

// Data word and instruction word
`define XLEN        32

// Register index, x0..x31
`define REG_ADDR_W  5

// ************************************************************************
// Constants
// ************************************************************************

// First fetch address after reset
`define RESET_PC    32'h0000_0000

// Cleared operand or register value
`define ZERO_WORD   32'h0000_0000

`endif

//--- src/rv_ex.sv
/*
 * Execute stage: ALU and the execute/writeback register.
 * ex_result_o is combinational and goes back to decode for forwarding.
 * wb_valid_o means a register write happens this cycle.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_ex (
    input  logic                    clk,
    input  logic                    reset_i,
    // From decode
    rv_stage_if.sink                de,
    // Forwarding path
    output logic [`XLEN-1:0]        ex_result_o,
    // Writeback triple
    output logic                    wb_valid_o,
    output logic [`REG_ADDR_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o
);
    import rv_pkg::*;

    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;

    // Only the low five bits shift
    assign shamt = de.op2[4:0];

    // ************************************************************************
    // ALU
    // ************************************************************************

    always_comb begin
        case (de.alu_op)
            ALU_ADD:  alu_result = de.op1 + de.op2;
            ALU_SUB:  alu_result = de.op1 - de.op2;
            ALU_SLL:  alu_result = de.op1 << shamt;
            // Signed and unsigned compares give 0 or 1
            ALU_SLT:  alu_result = {31'd0, $signed(de.op1) < $signed(de.op2)};
            ALU_SLTU: alu_result = {31'd0, de.op1 < de.op2};
            ALU_XOR:  alu_result = de.op1 ^ de.op2;
            ALU_SRL:  alu_result = de.op1 >> shamt;
            // Sign bit fills from the left
            ALU_SRA:  alu_result = $unsigned($signed(de.op1) >>> shamt);
            ALU_OR:   alu_result = de.op1 | de.op2;
            ALU_AND:  alu_result = de.op1 & de.op2;
            default:  alu_result = `ZERO_WORD;
        endcase
    end

    assign ex_result_o = alu_result;

    // Execute/writeback register, write strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= de.valid && de.wen;
        end
    end

    // Destination and data
    always_ff @(posedge clk) begin
        wb_rd_o   <= de.rd;
        wb_data_o <= alu_result;
    end

endmodule

//--- src/rv_fetch.sv
/*
 * PC and fetch/decode register.
 * Instruction memory is external and answers in the same cycle.
 * inst_valid_i low captures a bubble and holds the PC; no back-pressure.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_fetch (
    input  logic              clk,
    input  logic              reset_i,
    // Instruction memory
    input  logic [`XLEN-1:0]  inst_i,
    input  logic              inst_valid_i,
    output logic [`XLEN-1:0]  inst_addr_o,
    // To decode
    output logic [`XLEN-1:0]  fd_inst_o,
    output logic              fd_valid_o
);

    logic [`XLEN-1:0] pc_q;

    // Address straight from the PC register
    assign inst_addr_o = pc_q;

    // PC moves one word per accepted instruction
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (inst_valid_i) begin
            pc_q <= pc_q + `XLEN'd4;
        end
    end

    // Valid bit of the fetch/decode stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fd_valid_o <= 1'b0;
        end else begin
            fd_valid_o <= inst_valid_i;
        end
    end

    // Instruction word, meaningless while fd_valid_o is low
    always_ff @(posedge clk) begin
        fd_inst_o <= inst_i;
    end

endmodule

//--- src/rv_hazard_ctrl.sv
/*
 * Forwarding control; purely combinational, never stalls.
 * Execute wins over writeback when both hold the same rd.
 * x0 needs no check because wen and wb_valid are low for it.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_hazard_ctrl (
    // Sources from decode
    input  logic [`REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr_i,
    input  logic                    rs1_used_i,
    input  logic                    rs2_used_i,
    // Destination in execute
    rv_stage_if.mon                 ex,
    // Destination in writeback
    input  logic                    wb_valid_i,
    input  logic [`REG_ADDR_W-1:0]  wb_rd_i,
    // Operand selects
    output rv_pkg::fwd_sel_e        fwd1_o,
    output rv_pkg::fwd_sel_e        fwd2_o
);
    import rv_pkg::*;

    // Newest producer of one source register
    function automatic fwd_sel_e pick_source(input logic used,
                                             input logic [`REG_ADDR_W-1:0] rs,
                                             input logic ex_wen,
                                             input logic [`REG_ADDR_W-1:0] ex_rd,
                                             input logic wb_wen,
                                             input logic [`REG_ADDR_W-1:0] wb_rd);
        if (used && ex_wen && (ex_rd == rs)) begin
            pick_source = FWD_EX;
        end else if (used && wb_wen && (wb_rd == rs)) begin
            pick_source = FWD_WB;
        end else begin
            pick_source = FWD_REG;
        end
    endfunction

    assign fwd1_o = pick_source(rs1_used_i, rs1_addr_i, ex.wen, ex.rd, wb_valid_i, wb_rd_i);
    assign fwd2_o = pick_source(rs2_used_i, rs2_addr_i, ex.wen, ex.rd, wb_valid_i, wb_rd_i);

endmodule

//--- src/rv_id.sv
/*
 * Decode stage for OP-IMM and OP only.
 * Any other opcode, or an illegal funct7, leaves as a bubble with no write.
 * Operands are forwarded here, before the decode/execute register,
 * so execute never sees a stale register value.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_id (
    input  logic                    clk,
    input  logic                    reset_i,
    // Fetch/decode register
    input  logic [`XLEN-1:0]        fd_inst_i,
    input  logic                    fd_valid_i,
    // Register file read side
    output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
    output logic                    rs1_used_o,
    output logic                    rs2_used_o,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,
    // Forwarding
    input  rv_pkg::fwd_sel_e        fwd1_i,
    input  rv_pkg::fwd_sel_e        fwd2_i,
    input  logic [`XLEN-1:0]        ex_result_i,
    input  logic [`XLEN-1:0]        wb_data_i,
    // To execute
    rv_stage_if.src                 de
);
    import rv_pkg::*;

    // funct7 of SUB, SRA and SRAI
    localparam logic [6:0] F7_ALT = 7'b010_0000;

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`XLEN-1:0]        imm_sext;
    logic [`XLEN-1:0]        shamt_zext;
    logic                    is_op_imm;
    logic                    is_op;
    logic                    is_shift;
    logic                    legal;
    alu_op_e                 alu_op;
    logic [`XLEN-1:0]        rs1_fwd;
    logic [`XLEN-1:0]        rs2_fwd;
    logic [`XLEN-1:0]        op1;
    logic [`XLEN-1:0]        op2;

    // Pick one register operand from its forward select
    function automatic logic [`XLEN-1:0] pick_operand(input fwd_sel_e sel,
                                                      input logic [`XLEN-1:0] reg_val,
                                                      input logic [`XLEN-1:0] ex_val,
                                                      input logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_EX:  pick_operand = ex_val;
            FWD_WB:  pick_operand = wb_val;
            default: pick_operand = reg_val;
        endcase
    endfunction

    // ************************************************************************
    // Field split
    // ************************************************************************

    assign opcode     = fd_inst_i[6:0];
    assign rd         = fd_inst_i[11:7];
    assign funct3     = fd_inst_i[14:12];
    assign funct7     = fd_inst_i[31:25];
    assign rs1_addr_o = fd_inst_i[19:15];
    // rs2 and shamt share bits 24:20
    assign rs2_addr_o = fd_inst_i[24:20];
    assign imm_sext   = {{20{fd_inst_i[31]}}, fd_inst_i[31:20]};
    assign shamt_zext = {27'd0, fd_inst_i[24:20]};

    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_op     = (opcode == OPC_OP);
    assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);

    // Both groups read rs1, only OP reads rs2
    assign rs1_used_o = fd_valid_i && legal;
    assign rs2_used_o = fd_valid_i && legal && is_op;

    // ************************************************************************
    // ALU function and legality
    // ************************************************************************

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase

        // OP allows the alternate funct7 only on ADD/SUB and SRL/SRA
        // OP-IMM checks funct7 only on shifts, where it is imm[11:5]
        if (is_op) begin
            legal = (funct7 == 7'd0)
                 || ((funct7 == F7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        end else if (is_op_imm) begin
            legal = !is_shift || (funct7 == 7'd0)
                 || ((funct7 == F7_ALT) && (funct3 == 3'b101));
        end else begin
            legal = 1'b0;
        end
    end

    // ************************************************************************
    // Operand select
    // ************************************************************************

    assign rs1_fwd = pick_operand(fwd1_i, rs1_data_i, ex_result_i, wb_data_i);
    assign rs2_fwd = pick_operand(fwd2_i, rs2_data_i, ex_result_i, wb_data_i);

    always_comb begin
        op1 = legal ? rs1_fwd : `ZERO_WORD;
        if (!legal) begin
            op2 = `ZERO_WORD;
        end else if (is_op) begin
            op2 = rs2_fwd;
        end else if (is_shift) begin
            op2 = shamt_zext;
        end else begin
            op2 = imm_sext;
        end
    end

    // Decode/execute register, control part
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de.valid <= 1'b0;
            de.wen   <= 1'b0;
        end else begin
            de.valid <= fd_valid_i && legal;
            // x0 target dropped here once for the whole pipe
            de.wen   <= fd_valid_i && legal && (rd != '0);
        end
    end

    // Payload part
    always_ff @(posedge clk) begin
        de.alu_op <= alu_op;
        de.op1    <= op1;
        de.op2    <= op2;
        de.rd     <= rd;
    end

endmodule

//--- src/rv_pkg.sv
/*
 * Types shared by decode, hazard control and execute.
 * Only the OP-IMM and OP major opcodes exist; any other opcode is a bubble.
 * alu_op_e values are internal and carry no ISA meaning.
 */
package rv_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011
    } opcode_e;

    // ALU functions driven by decode
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Operand source for each register read in decode
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,   // register file value
        FWD_EX  = 2'd1,   // ALU result now in execute
        FWD_WB  = 2'd2    // result now in writeback
    } fwd_sel_e;

endpackage

//--- src/rv_regs.sv
/*
 * 32 x 32-bit register file, two combinational reads, one write.
 * No read bypass: same-cycle writeback data arrives through forwarding.
 * x0 reads zero because reset clears it and decode never targets it.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_regs (
    input  logic                    clk,
    input  logic                    reset_i,
    // Read ports
    input  logic [`REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [`XLEN-1:0]        rs1_data_o,
    output logic [`XLEN-1:0]        rs2_data_o,
    // Write port from writeback
    input  logic                    wb_valid_i,
    input  logic [`REG_ADDR_W-1:0]  wb_rd_i,
    input  logic [`XLEN-1:0]        wb_data_i
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_W;

    logic [`XLEN-1:0] regs_q [NUM_REGS];

    // Combinational reads
    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];

    // Write at the end of the writeback cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= `ZERO_WORD;
            end
        end else if (wb_valid_i) begin
            regs_q[wb_rd_i] <= wb_data_i;
        end
    end

endmodule

//--- src/rv_stage_if.sv
/*
 * Decode to execute bundle, all fields registered in decode.
 * wen is already low for rd x0, bubbles and unsupported opcodes.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

interface rv_stage_if;
    import rv_pkg::*;

    // Real instruction in execute
    logic                    valid;
    // ALU function
    alu_op_e                 alu_op;
    // Operands, already forwarded
    logic [`XLEN-1:0]        op1;
    logic [`XLEN-1:0]        op2;
    // Destination and its write enable
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    wen;

    // Decode drives the bundle
    modport src (
        output valid,
        output alu_op,
        output op1,
        output op2,
        output rd,
        output wen
    );

    // Execute consumes it
    modport sink (
        input  valid,
        input  alu_op,
        input  op1,
        input  op2,
        input  rd,
        input  wen
    );

    // Hazard control only needs the destination
    modport mon (
        input  rd,
        input  wen
    );

endinterface

//--- tests/rv_core_assertions.sv
/*
 * Protocol checks on the ports of every bound rv_core.
 * The bubble check assumes the fixed three-edge latency of the pipe.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_core_assertions (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    inst_valid_i,
    input  logic                    wb_valid_i,
    input  logic [`REG_ADDR_W-1:0]  wb_rd_i,
    input  logic [`XLEN-1:0]        wb_data_i
);

    // Writeback stays quiet for the whole reset
    a_no_write_in_reset : assert property (
        @(posedge clk) $past(reset_i) |-> !wb_valid_i
    ) else $error("wb_valid_o high while reset was asserted");

    // A bubble captured three samples back cannot write now
    a_bubble_no_write : assert property (
        @(posedge clk) disable iff (reset_i)
        wb_valid_i |-> $past(inst_valid_i, 3)
    ) else $error("wb_valid_o high three edges after a bubble capture");

    // Write target and data fully known
    a_write_known : assert property (
        @(posedge clk) disable iff (reset_i)
        wb_valid_i |-> !$isunknown({wb_rd_i, wb_data_i})
    ) else $error("wb_rd_o or wb_data_o unknown during a write");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_valid_i (inst_valid_i),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o),
    .wb_data_i    (wb_data_o)
);

//--- tests/tb_rv_core.sv
/*
 * Directed testbench for rv_core with a reference register model.
 * The ROM word is written just before each fetch, so the program follows issue order.
 * Each write must appear in order on the third edge counting the capture edge.
 * Random values come from a 32-bit Galois LFSR stepped once per bit.
 */
`timescale 1ns/100ps
`include "rv_defines.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int ROM_WORDS    = 1024;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 200;

    logic                    clk;
    logic                    reset_i;
    logic [`XLEN-1:0]        inst_i;
    logic                    inst_valid_i;
    logic [`XLEN-1:0]        inst_addr_o;
    logic                    wb_valid_o;
    logic [`REG_ADDR_W-1:0]  wb_rd_o;
    logic [`XLEN-1:0]        wb_data_o;

    logic [`XLEN-1:0]        rom [ROM_WORDS];
    logic [`XLEN-1:0]        model_regs [32];
    logic [31:0]             lfsr;
    int unsigned             edge_cnt;
    // Fetch address the next issue must see
    logic [`XLEN-1:0]        exp_pc;

    // Expected writes with the oldest first
    logic [`REG_ADDR_W-1:0]  exp_rd_q [$];
    logic [`XLEN-1:0]        exp_data_q [$];
    int unsigned             exp_edge_q [$];

    rv_core uut (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_addr_o  (inst_addr_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    // Combinational instruction memory
    assign inst_i = rom[inst_addr_o[11:2]];

    always #10 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // ************************************************************************
    // Helpers
    // ************************************************************************

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        // Taps of x^32 + x^22 + x^2 + x + 1
        if (state[0]) begin
            lfsr_step = (state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_step = state >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
        return value;
    endfunction

    // Random register x1..x7
    function automatic logic [4:0] pick_reg();
        logic [31:0] tmp;
        tmp = rand_bits(3);
        pick_reg = (tmp[2:0] == 3'd0) ? 5'd7 : {2'b00, tmp[2:0]};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] imm);
        enc_imm = {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // R-type indexed as ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    function automatic logic [31:0] enc_op(input int idx, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'd0;
        case (idx)
            0: f3 = 3'b000;
            1: begin
                f7 = 7'b010_0000;
                f3 = 3'b000;
            end
            2: f3 = 3'b001;
            3: f3 = 3'b010;
            4: f3 = 3'b011;
            5: f3 = 3'b100;
            6: f3 = 3'b101;
            7: begin
                f7 = 7'b010_0000;
                f3 = 3'b101;
            end
            8: f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        enc_op = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // ************************************************************************
    // Reference model from the RV32I rules
    // ************************************************************************

    task automatic model_exec(input logic [31:0] inst, output logic writes,
                              output logic [31:0] result);
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        opc = inst[6:0];
        a   = model_regs[inst[19:15]];
        b   = (opc == OPC_OP) ? model_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        sh  = b[4:0];
        case (inst[14:12])
            3'b000:  result = (opc == OPC_OP && inst[30]) ? a - b : a + b;
            3'b001:  result = a << sh;
            // Signed order equals unsigned order with the sign bits flipped
            3'b010:  result = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            3'b011:  result = (a < b) ? 32'd1 : 32'd0;
            3'b100:  result = a ^ b;
            3'b101:  result = (a >> sh) | ((inst[30] && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
            3'b110:  result = a | b;
            default: result = a & b;
        endcase
        writes = ((opc == OPC_OP) || (opc == OPC_OP_IMM)) && (inst[11:7] != 5'd0);
        if (writes) begin
            model_regs[inst[11:7]] = result;
        end
    endtask

    // Present one instruction for one capture edge
    task automatic issue(input logic [31:0] inst);
        logic        writes;
        logic [31:0] result;
        assert (inst_addr_o == exp_pc) else
            abort_run($sformatf("** Error @ %0t: inst_addr_o %h, expected %h", $time,
                                inst_addr_o, exp_pc));
        exp_pc = exp_pc + 4;
        rom[inst_addr_o[11:2]] = inst;
        inst_valid_i = 1'b1;
        model_exec(inst, writes, result);
        if (writes) begin
            exp_rd_q.push_back(inst[11:7]);
            exp_data_q.push_back(result);
            // Captured at edge_cnt + 1 and seen by the monitor after edge_cnt + 3
            exp_edge_q.push_back(edge_cnt + 3);
        end
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
    endtask

    task automatic idle(input int cycles);
        inst_valid_i = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_rd_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_rd_q.size() != 0) begin
            abort_run("Timeout: expected register writes never came out of the core");
        end
    endtask

    // Random 32-bit value into rd through a dependent triple
    task automatic load_random(input logic [4:0] rd);
        logic [31:0] tmp;
        tmp = rand_bits(12);
        issue(enc_imm(3'b000, rd, 5'd0, tmp[11:0]));
        tmp = rand_bits(5);
        issue(enc_imm(3'b001, rd, rd, {7'd0, tmp[4:0]}));
        tmp = rand_bits(12);
        issue(enc_imm(3'b100, rd, rd, tmp[11:0]));
    endtask

    // Writeback monitor sampled on the falling edge
    task automatic check_write();
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        int unsigned            due;
        if (exp_rd_q.size() == 0) begin
            abort_run($sformatf("** Error @ %0t: unexpected write to x%0d", $time, wb_rd_o));
        end else begin
            rd   = exp_rd_q.pop_front();
            data = exp_data_q.pop_front();
            due  = exp_edge_q.pop_front();
            assert (wb_rd_o == rd) else
                abort_run($sformatf("** Error @ %0t: write to x%0d, expected x%0d",
                                    $time, wb_rd_o, rd));
            assert (wb_data_o == data) else
                abort_run($sformatf("** Error @ %0t: x%0d got %h, expected %h",
                                    $time, rd, wb_data_o, data));
            assert (edge_cnt == due) else
                abort_run($sformatf("** Error @ %0t: x%0d written at edge %0d, expected %0d",
                                    $time, rd, edge_cnt, due));
        end
    endtask

    always @(negedge clk) begin
        if (!reset_i && wb_valid_o) begin
            check_write();
        end
    end

    // ************************************************************************
    // Directed tests
    // ************************************************************************

    task automatic check_idle_after_reset();
        repeat (8) begin
            assert (inst_addr_o == `RESET_PC) else
                abort_run($sformatf("** Error @ %0t: inst_addr_o %h while idle", $time,
                                    inst_addr_o));
            assert (!wb_valid_o) else
                abort_run($sformatf("** Error @ %0t: write while idle", $time));
            idle(1);
        end
    endtask

    // Each OP-IMM ALU op with a positive and a negative immediate
    task automatic imm_ops_sweep();
        logic [31:0] tmp;
        logic        neg;
        for (int f = 0; f < 8; f++) begin
            if (f != 1 && f != 5) begin
                for (int sign = 0; sign < 2; sign++) begin
                    neg = (sign != 0);
                    load_random(5'd1);
                    tmp = rand_bits(11);
                    issue(enc_imm(f[2:0], 5'd2, 5'd1, {neg, tmp[10:0]}));
                end
            end
        end
        wait_drain();
    endtask

    // Shifts on negative values
    task automatic negative_shifts();
        logic [31:0] tmp;
        for (int rep = 0; rep < 4; rep++) begin
            tmp = rand_bits(11);
            issue(enc_imm(3'b000, 5'd3, 5'd0, {1'b1, tmp[10:0]}));
            tmp = rand_bits(5);
            issue(enc_imm(3'b001, 5'd4, 5'd3, {7'd0, tmp[4:0]}));
            tmp = rand_bits(5);
            issue(enc_imm(3'b101, 5'd5, 5'd3, {7'd0, tmp[4:0]}));
            tmp = rand_bits(5);
            issue(enc_imm(3'b101, 5'd6, 5'd3, {7'b010_0000, tmp[4:0]}));
        end
        wait_drain();
    endtask

    // Every source is the previous or second-previous result
    task automatic dependent_chain();
        logic [31:0] tmp;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        logic [4:0]  rd;
        int          idx;
        load_random(5'd10);
        load_random(5'd11);
        prev2 = 5'd10;
        prev1 = 5'd11;
        for (int k = 0; k < 24; k++) begin
            rd  = 5'd10 + 5'((k + 2) % 4);
            tmp = rand_bits(4);
            // SUB and SRA first and random ops after
            idx = (k == 0) ? 1 : (k == 1) ? 7 : int'(tmp % 10);
            tmp = rand_bits(1);
            if (tmp[0]) begin
                issue(enc_op(idx, rd, prev2, prev1));
            end else begin
                issue(enc_op(idx, rd, prev1, prev2));
            end
            prev2 = prev1;
            prev1 = rd;
        end
        wait_drain();
    endtask

    // Random mix with bubble gaps of 0..3 cycles
    task automatic gap_mix();
        logic [31:0] tmp;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int k = 0; k < 40; k++) begin
            tmp = rand_bits(2);
            idle(int'(tmp));
            sel = rand_bits(1);
            if (sel[0]) begin
                tmp = rand_bits(4);
                issue(enc_op(int'(tmp % 10), pick_reg(), pick_reg(), pick_reg()));
            end else begin
                tmp = rand_bits(3);
                f3  = tmp[2:0];
                tmp = rand_bits(12);
                imm = tmp[11:0];
                // Shifts keep funct7 legal
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'd0;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = imm[11] ? 7'b010_0000 : 7'd0;
                end
                issue(enc_imm(f3, pick_reg(), pick_reg(), imm));
            end
        end
        wait_drain();
    endtask

    // x0 targets and foreign opcodes leave no trace
    task automatic no_write_cases();
        load_random(5'd5);
        issue(enc_imm(3'b000, 5'd0, 5'd5, 12'h123));
        issue(enc_op(0, 5'd12, 5'd0, 5'd0));
        // LUI and LOAD opcodes are not supported
        issue({20'hABCDE, 5'd5, 7'b011_0111});
        issue({12'h010, 5'd5, 3'b010, 5'd6, 7'b000_0011});
        issue(enc_op(8, 5'd0, 5'd5, 5'd5));
        idle(4);
        issue(enc_op(0, 5'd14, 5'd0, 5'd0));
        issue(enc_imm(3'b110, 5'd15, 5'd0, 12'h7FF));
        wait_drain();
    endtask

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        lfsr         = 32'h5c1;
        edge_cnt     = 0;
        exp_pc       = `RESET_PC;
        // Unused words carry a custom opcode tagged with the word index
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = {i[24:0], 7'b000_1011};
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = `ZERO_WORD;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;

        check_idle_after_reset();
        imm_ops_sweep();
        negative_shifts();
        dependent_chain();
        gap_mix();
        no_write_cases();
        // Room for any stray write to show up
        idle(8);

        if (exp_rd_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("Expected register writes were still pending at the end");
        end
    end

endmodule
